/* Bender.yml */
package:
  name: ex_stage

sources:
  - hdl/ex_pkg.sv
  - hdl/ex_alu.sv
  - hdl/ex_branch.sv
  - hdl/ex_csr_file.sv
  - hdl/ex_stage.sv
  - target: test
    files:
      - tb/tb_ex_stage.sv

/* compile.f */
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_csr_file.sv
hdl/ex_stage.sv
tb/tb_ex_stage.sv

/* hdl/ex_alu.sv */
// ****************************************
// integer ALU of the execute stage
// 64-bit and word ops, upper imm, link
// ****************************************
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::opcode_e opcode_i,
    input  ex_pkg::xlen_t   op1_i,
    input  ex_pkg::xlen_t   op2_i,
    output ex_pkg::xlen_t   alu_res_o
);

    // word result sign-extended from bit 31
    function automatic ex_pkg::xlen_t sext_w(input logic [ex_pkg::WLEN-1:0] w);
        return {{(ex_pkg::XLEN - ex_pkg::WLEN){w[ex_pkg::WLEN-1]}}, w};
    endfunction

    logic [5:0]              shamt;
    logic [4:0]              shamt_w;
    logic [ex_pkg::WLEN-1:0] op1_w;
    logic [ex_pkg::WLEN-1:0] op2_w;
    logic [ex_pkg::WLEN-1:0] addw_res;
    logic [ex_pkg::WLEN-1:0] subw_res;
    logic [ex_pkg::WLEN-1:0] sllw_res;
    logic [ex_pkg::WLEN-1:0] srlw_res;
    logic [ex_pkg::WLEN-1:0] sraw_res;
    logic                    lt_s;
    logic                    lt_u;
    ex_pkg::xlen_t           upper_imm;

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];
    assign op1_w   = op1_i[ex_pkg::WLEN-1:0];
    assign op2_w   = op2_i[ex_pkg::WLEN-1:0];

    assign addw_res = op1_w + op2_w;
    assign subw_res = op1_w - op2_w;
    assign sllw_res = op1_w << shamt_w;
    assign srlw_res = op1_w >> shamt_w;
    assign sraw_res = $signed(op1_w) >>> shamt_w;

    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    // 20-bit immediate placed at bit 12
    assign upper_imm = {{(ex_pkg::XLEN - 32){op2_i[19]}}, op2_i[19:0], 12'd0};

    always_comb begin
        case (opcode_i)
            ex_pkg::ADD:       alu_res_o = op1_i + op2_i;
            ex_pkg::SUB:       alu_res_o = op1_i - op2_i;
            ex_pkg::SLT:       alu_res_o = {{(ex_pkg::XLEN - 1){1'b0}}, lt_s};
            ex_pkg::SLTU:      alu_res_o = {{(ex_pkg::XLEN - 1){1'b0}}, lt_u};
            ex_pkg::XOR:       alu_res_o = op1_i ^ op2_i;
            ex_pkg::OR:        alu_res_o = op1_i | op2_i;
            ex_pkg::AND:       alu_res_o = op1_i & op2_i;
            ex_pkg::SLL:       alu_res_o = op1_i << shamt;
            ex_pkg::SRL:       alu_res_o = op1_i >> shamt;
            ex_pkg::SRA:       alu_res_o = $signed(op1_i) >>> shamt;
            ex_pkg::ADDW:      alu_res_o = sext_w(addw_res);
            ex_pkg::SUBW:      alu_res_o = sext_w(subw_res);
            ex_pkg::SLLW:      alu_res_o = sext_w(sllw_res);
            ex_pkg::SRLW:      alu_res_o = sext_w(srlw_res);
            ex_pkg::SRAW:      alu_res_o = sext_w(sraw_res);
            // op1 is zero for LUI, the pc for AUIPC
            ex_pkg::LUI_AUIPC: alu_res_o = op1_i + upper_imm;
            // op2 carries the pc of the jump
            ex_pkg::JAL_LINK:  alu_res_o = op2_i + 64'd4;
            default:           alu_res_o = '0;
        endcase
    end

endmodule

/* hdl/ex_branch.sv */
// ****************************************
// branch compare, flags a not-taken branch
// ****************************************
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::opcode_e opcode_i,
    input  ex_pkg::xlen_t   op1_i,
    input  ex_pkg::xlen_t   op2_i,
    output logic            branch_miss_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    // front end fetched the target, so a false condition needs pc + 4
    always_comb begin
        case (opcode_i)
            ex_pkg::BEQ:  branch_miss_o = !eq;
            ex_pkg::BNE:  branch_miss_o = eq;
            ex_pkg::BLT:  branch_miss_o = !lt_s;
            ex_pkg::BGE:  branch_miss_o = lt_s;
            ex_pkg::BLTU: branch_miss_o = !lt_u;
            ex_pkg::BGEU: branch_miss_o = lt_u;
            default:      branch_miss_o = 1'b0;
        endcase
    end

endmodule

/* hdl/ex_csr_file.sv */
// ****************************************
// machine CSRs with ECALL capture
// and trap / return vectors
// ****************************************
`timescale 1ns/1ps

module ex_csr_file #(
    parameter ex_pkg::xlen_t MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      stall_i,
    input  logic [ex_pkg::CSR_AW-1:0] csr_idx_i,
    input  logic                      csr_wr_en_i,
    input  ex_pkg::xlen_t             csr_wr_data_i,
    input  logic                      ecall_en_i,
    input  ex_pkg::xlen_t             pc_i,
    output ex_pkg::xlen_t             csr_rd_data_o,
    output ex_pkg::xlen_t             trap_vec_o,
    output ex_pkg::xlen_t             ret_vec_o
);

    ex_pkg::xlen_t mstatus_q;
    ex_pkg::xlen_t mscratch_q;
    ex_pkg::xlen_t mtvec_q;
    ex_pkg::xlen_t mepc_q;
    ex_pkg::xlen_t mcause_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q  <= '0;
            mscratch_q <= '0;
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (!stall_i) begin
            if (ecall_en_i) begin
                mepc_q   <= pc_i;
                mcause_q <= ex_pkg::CAUSE_ECALL_M;
            end else if (csr_wr_en_i) begin
                // unmapped index drops the write
                case (csr_idx_i)
                    ex_pkg::CSR_MSTATUS:  mstatus_q  <= csr_wr_data_i;
                    ex_pkg::CSR_MSCRATCH: mscratch_q <= csr_wr_data_i;
                    ex_pkg::CSR_MTVEC:    mtvec_q    <= csr_wr_data_i;
                    ex_pkg::CSR_MEPC:     mepc_q     <= csr_wr_data_i;
                    ex_pkg::CSR_MCAUSE:   mcause_q   <= csr_wr_data_i;
                    default:              ;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_idx_i)
            ex_pkg::CSR_MSTATUS:  csr_rd_data_o = mstatus_q;
            ex_pkg::CSR_MSCRATCH: csr_rd_data_o = mscratch_q;
            ex_pkg::CSR_MTVEC:    csr_rd_data_o = mtvec_q;
            ex_pkg::CSR_MEPC:     csr_rd_data_o = mepc_q;
            ex_pkg::CSR_MCAUSE:   csr_rd_data_o = mcause_q;
            default:              csr_rd_data_o = '0;
        endcase
    end

    assign trap_vec_o = mtvec_q;
    assign ret_vec_o  = mepc_q;

    // the stage decode never issues a CSR write and a trap together
    a_wr_ecall_excl: assert property (
        @(posedge clk) disable iff (reset_i)
        !(csr_wr_en_i && ecall_en_i)
    );

endmodule

/* hdl/ex_pkg.sv */
// ****************************************
// execute stage shared definitions
// widths, opcodes, CSR map and trap cause
// ****************************************
package ex_pkg;

    // register and word widths
    parameter int XLEN = 64;
    parameter int WLEN = 32;

    // CSR index width
    parameter int CSR_AW = 12;

    typedef logic [XLEN-1:0] xlen_t;

    // decoded operation, immediate forms share the register-form code
    typedef enum logic [7:0] {
        ADD       = 8'h00,
        SUB       = 8'h01,
        SLT       = 8'h02,
        SLTU      = 8'h03,
        XOR       = 8'h04,
        OR        = 8'h05,
        AND       = 8'h06,
        SLL       = 8'h07,
        SRL       = 8'h08,
        SRA       = 8'h09,
        ADDW      = 8'h10,
        SUBW      = 8'h11,
        SLLW      = 8'h12,
        SRLW      = 8'h13,
        SRAW      = 8'h14,
        LUI_AUIPC = 8'h20,
        JAL_LINK  = 8'h21,
        BEQ       = 8'h30,
        BNE       = 8'h31,
        BLT       = 8'h32,
        BGE       = 8'h33,
        BLTU      = 8'h34,
        BGEU      = 8'h35,
        LOAD      = 8'h40,
        STORE     = 8'h41,
        CSRRW     = 8'h50,
        CSRRS     = 8'h51,
        CSRRC     = 8'h52,
        ECALL     = 8'h60,
        MRET      = 8'h61,
        NOP       = 8'hff
    } opcode_e;

    // machine mode CSR addresses
    parameter logic [CSR_AW-1:0] CSR_MSTATUS  = 12'h300;
    parameter logic [CSR_AW-1:0] CSR_MTVEC    = 12'h305;
    parameter logic [CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
    parameter logic [CSR_AW-1:0] CSR_MEPC     = 12'h341;
    parameter logic [CSR_AW-1:0] CSR_MCAUSE   = 12'h342;

    // environment call from M-mode
    parameter xlen_t CAUSE_ECALL_M = 64'd11;

endpackage

/* hdl/ex_stage.sv */
// ****************************************
// RV64 execute stage top, result select,
// redirect priority and CSR write decode
// ****************************************
`timescale 1ns/1ps

module ex_stage #(
    parameter ex_pkg::xlen_t MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  logic            clk,
    input  logic            reset_i,
    input  ex_pkg::xlen_t   pc_i,
    input  ex_pkg::opcode_e opcode_i,
    input  ex_pkg::xlen_t   op1_i,
    input  ex_pkg::xlen_t   op2_i,
    input  logic [11:0]     ls_offset_i,
    input  logic            ex_stall_i,
    output ex_pkg::xlen_t   rd_data_o,
    output ex_pkg::xlen_t   ls_addr_o,
    output logic            redirect_o,
    output ex_pkg::xlen_t   redirect_pc_o
);

    ex_pkg::xlen_t             alu_res;
    logic                      branch_miss;
    logic [ex_pkg::CSR_AW-1:0] csr_idx;
    logic                      csr_op;
    logic                      csr_wr_en;
    ex_pkg::xlen_t             csr_wr_data;
    logic                      ecall_en;
    ex_pkg::xlen_t             csr_rd_data;
    ex_pkg::xlen_t             trap_vec;
    ex_pkg::xlen_t             ret_vec;

    ex_alu alu0 (
        .opcode_i  (opcode_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .alu_res_o (alu_res)
    );

    ex_branch branch0 (
        .opcode_i      (opcode_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .branch_miss_o (branch_miss)
    );

    ex_csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) csr0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (ex_stall_i),
        .csr_idx_i     (csr_idx),
        .csr_wr_en_i   (csr_wr_en),
        .csr_wr_data_i (csr_wr_data),
        .ecall_en_i    (ecall_en),
        .pc_i          (pc_i),
        .csr_rd_data_o (csr_rd_data),
        .trap_vec_o    (trap_vec),
        .ret_vec_o     (ret_vec)
    );

    assign csr_idx  = op2_i[ex_pkg::CSR_AW-1:0];
    assign ecall_en = opcode_i == ex_pkg::ECALL;
    assign csr_op   = (opcode_i == ex_pkg::CSRRW) || (opcode_i == ex_pkg::CSRRS) ||
                      (opcode_i == ex_pkg::CSRRC);

    // set and clear with a zero mask only read
    always_comb begin
        case (opcode_i)
            ex_pkg::CSRRW: begin
                csr_wr_en   = 1'b1;
                csr_wr_data = op1_i;
            end
            ex_pkg::CSRRS: begin
                csr_wr_en   = op1_i != '0;
                csr_wr_data = csr_rd_data | op1_i;
            end
            ex_pkg::CSRRC: begin
                csr_wr_en   = op1_i != '0;
                csr_wr_data = csr_rd_data & ~op1_i;
            end
            default: begin
                csr_wr_en   = 1'b0;
                csr_wr_data = '0;
            end
        endcase
    end

    assign rd_data_o = csr_op ? csr_rd_data : alu_res;

    assign ls_addr_o = ((opcode_i == ex_pkg::LOAD) || (opcode_i == ex_pkg::STORE)) ?
                       op1_i + {{(ex_pkg::XLEN - 12){ls_offset_i[11]}}, ls_offset_i} : '0;

    // trap, then return, then branch fall-through
    always_comb begin
        if (ecall_en) begin
            redirect_o    = 1'b1;
            redirect_pc_o = trap_vec;
        end else if (opcode_i == ex_pkg::MRET) begin
            redirect_o    = 1'b1;
            redirect_pc_o = ret_vec;
        end else if (branch_miss) begin
            redirect_o    = 1'b1;
            redirect_pc_o = pc_i + 64'd4;
        end else begin
            redirect_o    = 1'b0;
            redirect_pc_o = '0;
        end
    end

    a_nop_no_redirect: assert property (
        @(posedge clk) disable iff (reset_i)
        (opcode_i == ex_pkg::NOP) |-> !redirect_o
    );

endmodule

/* tb/tb_ex_stage.sv */
// ****************************************
// testbench for the RV64 execute stage
// ****************************************
`timescale 1ns/1ps

module tb_ex_stage;

    localparam ex_pkg::xlen_t MTVEC_RESET = 64'h0000_0000_8000_0200;
    localparam int N_ALU = 200;
    localparam int N_BR  = 40;
    localparam int N_LS  = 80;
    // random tests, about 60 directed CSR and trap cycles, and margin
    localparam int CYCLE_LIMIT = N_ALU + 6 * N_BR + N_LS + 480;

    logic            clk;
    logic            reset_i;
    ex_pkg::xlen_t   pc_i;
    ex_pkg::opcode_e opcode_i;
    ex_pkg::xlen_t   op1_i;
    ex_pkg::xlen_t   op2_i;
    logic [11:0]     ls_offset_i;
    logic            ex_stall_i;
    ex_pkg::xlen_t   rd_data_o;
    ex_pkg::xlen_t   ls_addr_o;
    logic            redirect_o;
    ex_pkg::xlen_t   redirect_pc_o;

    integer        seed = 32'hb60e;
    int            err_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    // mstatus, mscratch, mtvec, mepc, mcause
    ex_pkg::xlen_t csr_m [0:4];

    ex_stage #(.MTVEC_RESET(MTVEC_RESET)) dut0 (
        .clk(clk), .reset_i(reset_i), .pc_i(pc_i), .opcode_i(opcode_i),
        .op1_i(op1_i), .op2_i(op2_i), .ls_offset_i(ls_offset_i), .ex_stall_i(ex_stall_i),
        .rd_data_o(rd_data_o), .ls_addr_o(ls_addr_o), .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int csr_slot(input logic [11:0] idx);
        case (idx)
            12'h300: return 0;
            12'h340: return 1;
            12'h305: return 2;
            12'h341: return 3;
            12'h342: return 4;
            default: return -1;
        endcase
    endfunction

    function automatic ex_pkg::xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // edge values show up often
    function automatic ex_pkg::xlen_t rand_operand();
        case ($unsigned($random(seed)) % 6)
            0: return '0;
            1: return '1;
            2: return 64'h8000_0000_0000_0000;
            default: return rand_word();
        endcase
    endfunction

    function automatic void exp_result(
        input  ex_pkg::opcode_e op,
        input  ex_pkg::xlen_t   pc, a, b,
        input  logic [11:0]     off,
        output ex_pkg::xlen_t   rd, ls,
        output logic            redir,
        output ex_pkg::xlen_t   rpc
    );
        logic [31:0] w;
        logic        miss;
        int          slot;
        slot = csr_slot(b[11:0]);
        case (op)
            ex_pkg::ADDW: w = a[31:0] + b[31:0];
            ex_pkg::SUBW: w = a[31:0] - b[31:0];
            ex_pkg::SLLW: w = a[31:0] << b[4:0];
            ex_pkg::SRLW: w = a[31:0] >> b[4:0];
            ex_pkg::SRAW: w = $signed(a[31:0]) >>> b[4:0];
            default:      w = '0;
        endcase
        case (op)
            ex_pkg::ADD:       rd = a + b;
            ex_pkg::SUB:       rd = a - b;
            ex_pkg::SLT:       rd = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ex_pkg::SLTU:      rd = (a < b) ? 64'd1 : 64'd0;
            ex_pkg::XOR:       rd = a ^ b;
            ex_pkg::OR:        rd = a | b;
            ex_pkg::AND:       rd = a & b;
            ex_pkg::SLL:       rd = a << b[5:0];
            ex_pkg::SRL:       rd = a >> b[5:0];
            ex_pkg::SRA:       rd = $signed(a) >>> b[5:0];
            ex_pkg::ADDW, ex_pkg::SUBW, ex_pkg::SLLW, ex_pkg::SRLW,
            ex_pkg::SRAW:      rd = {{32{w[31]}}, w};
            ex_pkg::LUI_AUIPC: rd = a + {{32{b[19]}}, b[19:0], 12'h000};
            ex_pkg::JAL_LINK:  rd = b + 64'd4;
            ex_pkg::CSRRW, ex_pkg::CSRRS,
            ex_pkg::CSRRC:     rd = (slot < 0) ? 64'd0 : csr_m[slot];
            default:           rd = '0;
        endcase
        case (op)
            ex_pkg::BEQ:  miss = a != b;
            ex_pkg::BNE:  miss = a == b;
            ex_pkg::BLT:  miss = !($signed(a) < $signed(b));
            ex_pkg::BGE:  miss = $signed(a) < $signed(b);
            ex_pkg::BLTU: miss = !(a < b);
            ex_pkg::BGEU: miss = a < b;
            default:      miss = 1'b0;
        endcase
        ls = (op == ex_pkg::LOAD || op == ex_pkg::STORE) ? a + {{52{off[11]}}, off} : 64'd0;
        redir = (op == ex_pkg::ECALL) || (op == ex_pkg::MRET) || miss;
        if (op == ex_pkg::ECALL)
            rpc = csr_m[2];
        else if (op == ex_pkg::MRET)
            rpc = csr_m[3];
        else
            rpc = miss ? pc + 64'd4 : 64'd0;
    endfunction

    task automatic report_mismatch(input string name, input ex_pkg::xlen_t e, a);
        err_count++;
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, e, a);
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin : compare
        ex_pkg::xlen_t e_rd;
        ex_pkg::xlen_t e_ls;
        ex_pkg::xlen_t e_rpc;
        logic          e_redir;
        if (!reset_i) begin
            exp_result(opcode_i, pc_i, op1_i, op2_i, ls_offset_i, e_rd, e_ls, e_redir, e_rpc);
            check_count++;
            if (rd_data_o !== e_rd)
                report_mismatch("rd_data_o", e_rd, rd_data_o);
            if (ls_addr_o !== e_ls)
                report_mismatch("ls_addr_o", e_ls, ls_addr_o);
            if (redirect_o !== e_redir)
                report_mismatch("redirect_o", e_redir, redirect_o);
            if (redirect_pc_o !== e_rpc)
                report_mismatch("redirect_pc_o", e_rpc, redirect_pc_o);
        end
    end

    // CSR model follows the write rule at each edge
    always @(posedge clk) begin : csr_model
        int            slot;
        ex_pkg::xlen_t old;
        cycle_count++;
        slot = csr_slot(op2_i[11:0]);
        old  = (slot < 0) ? 64'd0 : csr_m[slot];
        if (reset_i) begin
            for (int i = 0; i < 5; i++)
                csr_m[i] = '0;
            csr_m[2] = MTVEC_RESET;
        end else if (!ex_stall_i) begin
            if (opcode_i == ex_pkg::ECALL) begin
                csr_m[3] = pc_i;
                csr_m[4] = 64'd11;
            end else if (slot >= 0) begin
                if (opcode_i == ex_pkg::CSRRW)
                    csr_m[slot] = op1_i;
                else if (opcode_i == ex_pkg::CSRRS && op1_i != '0)
                    csr_m[slot] = old | op1_i;
                else if (opcode_i == ex_pkg::CSRRC && op1_i != '0)
                    csr_m[slot] = old & ~op1_i;
            end
        end
    end

    task automatic issue_op(input ex_pkg::opcode_e op, input ex_pkg::xlen_t pc, a, b,
                            input logic [11:0] off, input logic stall);
        @(posedge clk);
        #2;
        opcode_i    = op;
        pc_i        = pc;
        op1_i       = a;
        op2_i       = b;
        ls_offset_i = off;
        ex_stall_i  = stall;
    endtask

    task automatic csr_access(input ex_pkg::opcode_e op, input ex_pkg::xlen_t val,
                              input logic [11:0] idx, input logic stall);
        ex_pkg::xlen_t r;
        r = rand_word();
        issue_op(op, r & ~64'h3, val, {r[63:12], idx}, 12'h000, stall);
    endtask

    task automatic finish_test(input string name, input int err_start);
        @(negedge clk);
        #1;
        $display("test %s finished with %0d errors", name, err_count - err_start);
    endtask

    initial begin : stimulus
        int            k;
        int            code;
        int            start;
        ex_pkg::xlen_t a;
        logic [11:0]   csr_list [0:5];
        reset_i     = 1'b1;
        pc_i        = '0;
        opcode_i    = ex_pkg::NOP;
        op1_i       = '0;
        op2_i       = '0;
        ls_offset_i = '0;
        ex_stall_i  = 1'b0;
        csr_list    = '{12'h300, 12'h340, 12'h305, 12'h341, 12'h342, 12'h7c0};
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;

        start = err_count;
        for (int i = 0; i < N_ALU; i++) begin
            // ADD..SRA, word forms, then upper imm and link
            k    = $unsigned($random(seed)) % 17;
            code = (k < 10) ? k : (k < 15) ? k + 6 : k + 17;
            issue_op(ex_pkg::opcode_e'(code[7:0]), rand_word() & ~64'h3, rand_operand(),
                     rand_operand(), 12'h000, 1'b0);
        end
        finish_test("alu", start);

        start = err_count;
        for (int j = 0; j < 6; j++) begin
            for (int i = 0; i < N_BR; i++) begin
                code = 8'h30 + j;
                a    = rand_operand();
                issue_op(ex_pkg::opcode_e'(code[7:0]), rand_word() & ~64'h3, a,
                         ($random(seed) % 4 == 0) ? a : rand_operand(), 12'h000, 1'b0);
            end
        end
        finish_test("branch", start);

        start = err_count;
        for (int i = 0; i < N_LS; i++) begin
            code = (i % 4 == 3) ? 8'h00 : 8'h40 + (i % 2);
            a    = rand_word();
            issue_op(ex_pkg::opcode_e'(code[7:0]), rand_word() & ~64'h3, rand_word(),
                     rand_word(), a[11:0], 1'b0);
        end
        finish_test("load_store", start);

        start = err_count;
        for (int j = 0; j < 6; j++) begin
            csr_access(ex_pkg::CSRRS, '0, csr_list[j], 1'b0);
            csr_access(ex_pkg::CSRRW, rand_word(), csr_list[j], 1'b0);
            csr_access(ex_pkg::CSRRS, '0, csr_list[j], 1'b0);
            csr_access(ex_pkg::CSRRS, rand_word(), csr_list[j], 1'b0);
            csr_access(ex_pkg::CSRRC, '0, csr_list[j], 1'b0);
            csr_access(ex_pkg::CSRRC, rand_word(), csr_list[j], 1'b0);
            csr_access(ex_pkg::CSRRS, '0, csr_list[j], 1'b0);
        end
        finish_test("csr", start);

        start = err_count;
        csr_access(ex_pkg::CSRRW, 64'h0000_0000_8000_0400, 12'h305, 1'b0);
        issue_op(ex_pkg::ECALL, rand_word() & ~64'h3, rand_word(), rand_word(), 12'h000, 1'b0);
        csr_access(ex_pkg::CSRRS, '0, 12'h341, 1'b0);
        csr_access(ex_pkg::CSRRS, '0, 12'h342, 1'b0);
        csr_access(ex_pkg::CSRRW, 64'h0000_0000_8000_1234, 12'h341, 1'b0);
        issue_op(ex_pkg::MRET, rand_word() & ~64'h3, rand_word(), rand_word(), 12'h000, 1'b0);
        finish_test("trap", start);

        start = err_count;
        csr_access(ex_pkg::CSRRW, 64'h5555_aaaa_0000_ffff, 12'h340, 1'b1);
        csr_access(ex_pkg::CSRRS, '0, 12'h340, 1'b0);
        issue_op(ex_pkg::NOP, '0, '0, '0, 12'h000, 1'b0);
        finish_test("stall", start);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin : watchdog
        wait (cycle_count >= CYCLE_LIMIT);
        $display("run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

endmodule
